// File: build.f
+incdir+tb
verilog/enable_gen_pkg.sv
verilog/enable_gen_regs.sv
verilog/enable_timebase.sv
verilog/enable_phase_out.sv
verilog/enable_gen_top.sv
tb/enable_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the enable generator testbench with Verilator and runs it
# Exits with zero only when the run reports a full pass
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module enable_gen_tb -o enable_gen_sim

out=$(./obj_dir/enable_gen_sim)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi

// File: tb/enable_gen_model.svh
//******************************
// Reference model of the enable generator, stepped once per clock edge
// Included inside the testbench module after the package import
// model_step takes the input values held at that edge
//******************************
`ifndef ENABLE_GEN_MODEL_SVH
`define ENABLE_GEN_MODEL_SVH

// Software-visible registers
logic               m_ctrl_ext_tb;
logic [COUNT_W-1:0] m_period;
logic [COUNT_W-1:0] m_thresh;

// Counter and the shadows that steer it
logic [COUNT_W-1:0] m_count;
logic [COUNT_W-1:0] m_period_act;
logic [COUNT_W-1:0] m_thresh_act;

// Predicted outputs after the edge
logic               m_en_out;
logic               m_rvalid;
logic [DATA_W-1:0]  m_rdata;

task automatic model_reset();
    m_ctrl_ext_tb = 1'b0;
    m_period      = '0;
    m_thresh      = '0;
    m_count       = '0;
    m_period_act  = '0;
    m_thresh_act  = '0;
    m_en_out      = 1'b0;
    m_rvalid      = 1'b0;
    m_rdata       = '0;
endtask

// Register view as software sees it, unmapped addresses give zero
function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] value;
    value = '0;
    if (addr == ADDR_CTRL) begin
        value[CTRL_EXT_TB] = m_ctrl_ext_tb;
    end else if (addr == ADDR_PERIOD) begin
        value = m_period;
    end else if (addr == ADDR_THRESH) begin
        value = m_thresh;
    end
    return value;
endfunction

task automatic model_step(input logic run, input logic ext, input logic wr, input logic rd,
                          input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
    logic               step;
    logic               old_ext_tb;
    logic [COUNT_W-1:0] old_period;
    logic [COUNT_W-1:0] old_thresh;
    logic [COUNT_W-1:0] next_count;
    // Everything below works from the state held before this edge
    old_ext_tb = m_ctrl_ext_tb;
    old_period = m_period;
    old_thresh = m_thresh;
    step       = old_ext_tb ? ext : 1'b1;
    m_en_out   = run && step && (m_count == m_thresh_act);
    // A read in the same cycle as a write sees the old value
    m_rvalid = rd;
    if (rd) begin
        m_rdata = model_read(addr);
    end
    if (wr) begin
        if (addr == ADDR_CTRL) begin
            m_ctrl_ext_tb = wdata[CTRL_EXT_TB];
        end else if (addr == ADDR_PERIOD) begin
            m_period = wdata[COUNT_W-1:0];
        end else if (addr == ADDR_THRESH) begin
            m_thresh = wdata[COUNT_W-1:0];
        end
    end
    next_count = m_count + 1'b1;
    if (!run) begin
        m_count      = '0;
        m_period_act = old_period;
        m_thresh_act = old_thresh;
    end else if (step) begin
        if (next_count >= m_period_act) begin
            // Wrap, new register values become active here
            m_count      = '0;
            m_period_act = old_period;
            m_thresh_act = old_thresh;
        end else begin
            m_count = next_count;
        end
    end
endtask

`endif

// File: tb/enable_gen_tb.sv
//******************************
// Testbench for the enable generator top level
// Stimulus comes from $random on a fixed seed
// All outputs are compared with the included model after every edge
//******************************
`timescale 1ns/1ns

module enable_gen_tb;

    import enable_gen_pkg::*;

    logic              clk;
    logic              rst;
    logic              gen_en;
    logic              ext_tick;
    logic              reg_wr;
    logic              reg_rd;
    logic [ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic [DATA_W-1:0] reg_rdata;
    logic              reg_rvalid;
    logic              en_out;

    integer seed;
    int     errors;
    int     test_errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    // Pulses on en_out and running ticks seen since the last clear
    int     pulses;
    int     ticks;

    `include "enable_gen_model.svh"

    enable_gen_top uut (
        .clk        (clk),
        .rst        (rst),
        .gen_en     (gen_en),
        .ext_tick   (ext_tick),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .en_out     (en_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard limit on the whole run
    initial begin
        #100000;
        $display("Timeout: the test sequence did not finish within 100000 ns");
        $display("Some tests failed");
        $finish;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    // Mapped addresses three times out of four, any address otherwise
    function automatic logic [ADDR_W-1:0] pick_addr();
        int unsigned r;
        r = rand_below(4);
        case (r)
            0: return ADDR_CTRL;
            1: return ADDR_PERIOD;
            2: return ADDR_THRESH;
            default: return ADDR_W'(rand_below(16));
        endcase
    endfunction

    task automatic check_enable(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_rdata(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            test_errors++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    // Called 1 ns after an edge, drives the inputs and compares after the next edge
    task automatic cycle(input logic run, input logic ext, input logic wr, input logic rd,
                         input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        gen_en    = run;
        ext_tick  = ext;
        reg_wr    = wr;
        reg_rd    = rd;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(posedge clk);
        model_step(run, ext, wr, rd, addr, wdata);
        #1;
        check_enable("en_out", en_out, m_en_out);
        check_enable("reg_rvalid", reg_rvalid, m_rvalid);
        if (m_rvalid) begin
            check_rdata("reg_rdata", reg_rdata, m_rdata);
        end
        if (en_out === 1'b1) begin
            pulses++;
        end
        if (run && ext) begin
            ticks++;
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        cycle(gen_en, 1'b0, 1'b1, 1'b0, addr, wdata);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int n;
        n = 0;
        cycle(gen_en, 1'b0, 1'b0, 1'b1, addr, '0);
        while (reg_rvalid !== 1'b1 && n < 8) begin
            cycle(gen_en, 1'b0, 1'b0, 1'b0, '0, '0);
            n++;
        end
        if (reg_rvalid !== 1'b1) begin
            errors++;
            test_errors++;
            $display("reg_rvalid never rose after a read of address %h", addr);
        end
        data = reg_rdata;
    endtask

    // ext_tick is random throughout, the internal timebase ignores it
    task automatic run_cycles(input logic run, input int n);
        int k;
        for (k = 0; k < n; k++) begin
            cycle(run, rand_below(2) == 1, 1'b0, 1'b0, '0, '0);
        end
    endtask

    // Runs at least one cycle and stops at the next en_out pulse
    task automatic wait_pulse(input int limit);
        int n;
        n = 0;
        do begin
            cycle(1'b1, rand_below(2) == 1, 1'b0, 1'b0, '0, '0);
            n++;
        end while (en_out !== 1'b1 && n < limit);
        if (en_out !== 1'b1) begin
            errors++;
            test_errors++;
            $display("No pulse on en_out within %0d cycles at %0t", limit, $time);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [DATA_W-1:0] rdata;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              run;
        logic              wr;
        logic              rd;
        int                period;
        int                thresh;
        int                i;
        seed         = 32'h29602fc7;
        errors       = 0;
        test_errors  = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        pulses       = 0;
        ticks        = 0;
        rst          = 1'b1;
        gen_en       = 1'b0;
        ext_tick     = 1'b0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Everything is zero out of reset
        check_enable("en_out", en_out, 1'b0);
        check_enable("reg_rvalid", reg_rvalid, 1'b0);
        read_reg(ADDR_CTRL, rdata);
        check_rdata("reg_rdata", rdata, '0);
        read_reg(ADDR_PERIOD, rdata);
        check_rdata("reg_rdata", rdata, '0);
        read_reg(ADDR_THRESH, rdata);
        check_rdata("reg_rdata", rdata, '0);
        finish_test("reset state");

        // Random writes and reads, the model checks every read
        for (i = 0; i < 24; i++) begin
            addr  = pick_addr();
            wdata = $random(seed);
            write_reg(addr, wdata);
            read_reg(pick_addr(), rdata);
        end
        read_reg(ADDR_CTRL, rdata);
        read_reg(ADDR_PERIOD, rdata);
        read_reg(ADDR_THRESH, rdata);
        finish_test("register readback");

        // One pulse per period on the internal timebase
        period = 2 + int'(rand_below(39));
        thresh = int'(rand_below(period));
        write_reg(ADDR_CTRL, '0);
        write_reg(ADDR_PERIOD, DATA_W'(period));
        write_reg(ADDR_THRESH, DATA_W'(thresh));
        // The shadows pick up the last write at the next stopped edge
        run_cycles(1'b0, 1);
        wait_pulse(period + 4);
        pulses = 0;
        run_cycles(1'b1, 3 * period);
        check_count("en_out pulse count", pulses, 3);
        pulses = 0;
        run_cycles(1'b0, 20);
        check_count("en_out pulses while stopped", pulses, 0);
        finish_test("internal timebase");

        // New period written mid-period lands at the next wrap
        period = 8 + int'(rand_below(33));
        thresh = int'(rand_below(period));
        write_reg(ADDR_PERIOD, DATA_W'(period));
        write_reg(ADDR_THRESH, DATA_W'(thresh));
        run_cycles(1'b0, 1);
        wait_pulse(period + 4);
        run_cycles(1'b1, 1 + int'(rand_below(period / 2)));
        period = 2 + int'(rand_below(39));
        thresh = int'(rand_below(period));
        write_reg(ADDR_PERIOD, DATA_W'(period));
        write_reg(ADDR_THRESH, DATA_W'(thresh));
        // The first pulse may still belong to the old period, the second cannot
        // A wrap between the two writes runs one period on the old threshold
        wait_pulse(2 * 40 + 4);
        wait_pulse(2 * 40 + 4);
        pulses = 0;
        run_cycles(1'b1, 2 * period);
        check_count("en_out pulse count", pulses, 2);
        run_cycles(1'b0, 4);
        finish_test("period change");

        // External timebase, one pulse per period ticks
        period = 2 + int'(rand_below(11));
        thresh = int'(rand_below(period));
        write_reg(ADDR_CTRL, DATA_W'(1) << CTRL_EXT_TB);
        write_reg(ADDR_PERIOD, DATA_W'(period));
        write_reg(ADDR_THRESH, DATA_W'(thresh));
        run_cycles(1'b0, 1);
        wait_pulse(8 * period + 32);
        pulses = 0;
        ticks  = 0;
        run_cycles(1'b1, 300);
        check_count("en_out pulse count", pulses, ticks / period);
        run_cycles(1'b0, 2);
        write_reg(ADDR_THRESH, DATA_W'(period + int'(rand_below(5))));
        run_cycles(1'b0, 1);
        pulses = 0;
        run_cycles(1'b1, 200);
        check_count("en_out pulses above period", pulses, 0);
        run_cycles(1'b0, 2);
        write_reg(ADDR_CTRL, '0);
        finish_test("external timebase");

        // Mixed traffic with small periods so that pulses stay frequent
        run = 1'b0;
        for (i = 0; i < 3000; i++) begin
            if (rand_below(50) == 0) begin
                run = ~run;
            end
            wr   = (rand_below(10) == 0);
            rd   = (rand_below(5) == 0);
            addr = pick_addr();
            if (addr == ADDR_CTRL) begin
                wdata = DATA_W'(rand_below(2));
            end else begin
                wdata = DATA_W'(rand_below(24));
            end
            cycle(run, rand_below(2) == 1, wr, rd, addr, wdata);
        end
        finish_test("random mix");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/enable_gen_pkg.sv
//******************************
// Shared widths, register map and control bits of the enable generator
// Register addresses are byte addresses on a 4-bit register port
// COUNT_W must not exceed DATA_W, period and threshold are taken from
// the low bits of the write data
//******************************
package enable_gen_pkg;

    // Width of the period counter and of the period and threshold registers
    localparam int COUNT_W = 32;

    // Register port data width
    localparam int DATA_W = 32;

    // Register port address width, byte addressed
    localparam int ADDR_W = 4;

    // Control register, holds the timebase selection
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 4'h0;

    // Period register, the counter wraps when count+1 reaches this value
    localparam logic [ADDR_W-1:0] ADDR_PERIOD = 4'h4;

    // Threshold register, the phase at which the enable pulse is emitted
    localparam logic [ADDR_W-1:0] ADDR_THRESH = 4'h8;

    // Control bit that selects the external timebase
    // When set the counter advances only on ext_tick, otherwise on every clock
    localparam int CTRL_EXT_TB = 0;

endpackage

// File: verilog/enable_gen_regs.sv
//******************************
// Software register block of the enable generator
// Writes land at the strobe edge, reads return one cycle later
// Unmapped addresses are ignored on write and read as zero
//******************************
`timescale 1ns/1ns

module enable_gen_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               reg_wr,
    input  logic                               reg_rd,
    input  logic [enable_gen_pkg::ADDR_W-1:0]  reg_addr,
    input  logic [enable_gen_pkg::DATA_W-1:0]  reg_wdata,
    output logic [enable_gen_pkg::DATA_W-1:0]  reg_rdata,
    output logic                               reg_rvalid,
    output logic                               ctrl_ext_tb,
    output logic [enable_gen_pkg::COUNT_W-1:0] period_reg,
    output logic [enable_gen_pkg::COUNT_W-1:0] thresh_reg
);

    import enable_gen_pkg::*;

    // Combinational view of the addressed register, sampled on a read strobe
    logic [DATA_W-1:0] rd_mux;

    // Only the timebase bit of the control register is implemented
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_ext_tb <= 1'b0;
            period_reg  <= '0;
            thresh_reg  <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                ADDR_CTRL: begin
                    ctrl_ext_tb <= reg_wdata[CTRL_EXT_TB];
                end
                ADDR_PERIOD: begin
                    period_reg <= reg_wdata[COUNT_W-1:0];
                end
                ADDR_THRESH: begin
                    thresh_reg <= reg_wdata[COUNT_W-1:0];
                end
                default: begin
                    // Writes outside the map have no effect
                end
            endcase
        end
    end

    // Readback mux
    // The control register shows the timebase bit in its own position,
    // all other control bits read as zero
    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            ADDR_CTRL: begin
                rd_mux[CTRL_EXT_TB] = ctrl_ext_tb;
            end
            ADDR_PERIOD: begin
                rd_mux = DATA_W'(period_reg);
            end
            ADDR_THRESH: begin
                rd_mux = DATA_W'(thresh_reg);
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // The valid strobe follows the read strobe by exactly one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    // Read data is captured at the strobe edge and holds until the next read
    // A write in the same cycle has not landed yet, so the old value is returned
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

// File: verilog/enable_gen_top.sv
//******************************
// Enable generator top level
// Register port has no back-pressure, reads take one cycle
// en_out follows a matching counter step by one cycle
//******************************
`timescale 1ns/1ns

module enable_gen_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               gen_en,
    input  logic                               ext_tick,
    input  logic                               reg_wr,
    input  logic                               reg_rd,
    input  logic [enable_gen_pkg::ADDR_W-1:0]  reg_addr,
    input  logic [enable_gen_pkg::DATA_W-1:0]  reg_wdata,
    output logic [enable_gen_pkg::DATA_W-1:0]  reg_rdata,
    output logic                               reg_rvalid,
    output logic                               en_out
);

    import enable_gen_pkg::*;

    // Register block to timebase
    logic               ctrl_ext_tb;
    logic [COUNT_W-1:0] period_reg;
    logic [COUNT_W-1:0] thresh_reg;

    // Timebase to pulse stage
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] thresh_active;
    logic               tick;

    enable_gen_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .ctrl_ext_tb (ctrl_ext_tb),
        .period_reg  (period_reg),
        .thresh_reg  (thresh_reg)
    );

    enable_timebase u_timebase (
        .clk           (clk),
        .rst           (rst),
        .gen_en        (gen_en),
        .ext_tick      (ext_tick),
        .ctrl_ext_tb   (ctrl_ext_tb),
        .period_reg    (period_reg),
        .thresh_reg    (thresh_reg),
        .count         (count),
        .thresh_active (thresh_active),
        .tick          (tick)
    );

    enable_phase_out u_phase_out (
        .clk           (clk),
        .rst           (rst),
        .gen_en        (gen_en),
        .tick          (tick),
        .count         (count),
        .thresh_active (thresh_active),
        .en_out        (en_out)
    );

endmodule

// File: verilog/enable_phase_out.sv
//******************************
// Phase compare and enable pulse register
// The pulse is high for the one cycle after a matching tick
// A threshold at or above the period is never reached and gives no pulse
//******************************
`timescale 1ns/1ns

module enable_phase_out (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               gen_en,
    input  logic                               tick,
    input  logic [enable_gen_pkg::COUNT_W-1:0] count,
    input  logic [enable_gen_pkg::COUNT_W-1:0] thresh_active,
    output logic                               en_out
);

    import enable_gen_pkg::*;

    // Counter value that matches the active threshold
    logic phase_match;

    // Qualified match, the counter must be running and stepping this cycle
    logic hit;

    assign phase_match = (count == thresh_active);

    // Gating on tick keeps a held count under the external timebase
    // from producing more than one pulse per step
    // gen_en is tested here and nowhere else on the pulse path
    assign hit = gen_en && tick && phase_match;

    // One registered stage between the compare and the output
    always_ff @(posedge clk) begin
        if (rst) begin
            en_out <= 1'b0;
        end else begin
            en_out <= hit;
        end
    end

endmodule

// File: verilog/enable_timebase.sv
//******************************
// Period counter with shadowed period and threshold
// New register values take effect at the next wrap, or at once while stopped
// A period of 0 or 1 keeps the count at zero
//******************************
`timescale 1ns/1ns

module enable_timebase (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               gen_en,
    input  logic                               ext_tick,
    input  logic                               ctrl_ext_tb,
    input  logic [enable_gen_pkg::COUNT_W-1:0] period_reg,
    input  logic [enable_gen_pkg::COUNT_W-1:0] thresh_reg,
    output logic [enable_gen_pkg::COUNT_W-1:0] count,
    output logic [enable_gen_pkg::COUNT_W-1:0] thresh_active,
    output logic                               tick
);

    import enable_gen_pkg::*;

    // Shadow of the period register, only this copy steers the counter
    logic [COUNT_W-1:0] period_active;

    // Candidate next count and the wrap decision taken from it
    logic [COUNT_W-1:0] count_inc;
    logic               wrap;

    // Timebase selection
    // With the internal timebase every clock is a tick
    assign tick = ctrl_ext_tb ? ext_tick : 1'b1;

    // The count is always below the shadow period after the first wrap,
    // so the increment cannot overflow COUNT_W bits
    assign count_inc = count + 1'b1;
    assign wrap      = (count_inc >= period_active);

    always_ff @(posedge clk) begin
        if (rst) begin
            count         <= '0;
            period_active <= '0;
            thresh_active <= '0;
        end else if (!gen_en) begin
            // Stopped, so the counter sits at zero and the shadows track
            // the registers so that the first period runs with fresh values
            count         <= '0;
            period_active <= period_reg;
            thresh_active <= thresh_reg;
        end else if (tick) begin
            if (wrap) begin
                // Period boundary, the only point where running values change
                count         <= '0;
                period_active <= period_reg;
                thresh_active <= thresh_reg;
            end else begin
                count <= count_inc;
            end
        end
    end

endmodule
